//--- hw/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define NB_DATA         32
`define NB_REG_ADDR     5
`define N_REGS          32
`define NB_OPCODE       6
`define NB_IMM          16
`define NB_FUNCT        6

`define RTYPE_OPCODE    6'h00
`define BEQ_OPCODE      6'h04   // branch on equal
`define BNE_OPCODE      6'h05   // branch on not equal
`define ADDI_OPCODE     6'h08
`define SLTI_OPCODE     6'h0a
`define ANDI_OPCODE     6'h0c   // logical, zero extended imm
`define ORI_OPCODE      6'h0d
`define XORI_OPCODE     6'h0e
`define LUI_OPCODE      6'h0f   // imm goes to upper half
`define LB_OPCODE       6'h20
`define LH_OPCODE       6'h21
`define LHU_OPCODE      6'h22
`define LW_OPCODE       6'h23
`define LWU_OPCODE      6'h24
`define LBU_OPCODE      6'h25
`define SB_OPCODE       6'h28
`define SH_OPCODE       6'h29
`define SW_OPCODE       6'h2b
`define J_OPCODE        6'h02
`define JAL_OPCODE      6'h03   // link write handled elsewhere

`endif

//--- hw/mips_pkg.sv
`include "mips_macros.svh"

package mips_pkg;

    // data or instruction word
    typedef logic [`NB_DATA-1:0] word_t;

    // register file index
    typedef logic [`NB_REG_ADDR-1:0] reg_addr_t;

    // opcode, also forwarded to EX as alu op
    typedef logic [`NB_OPCODE-1:0] opcode_t;

    // r-type function field
    typedef logic [`NB_FUNCT-1:0] funct_t;

    // raw immediate field
    typedef logic [`NB_IMM-1:0] imm_t;

    // j-type target, what is left after the opcode
    typedef logic [`NB_DATA-`NB_OPCODE-1:0] jump_target_t;

endpackage

//--- hw/control_unit.sv
`include "mips_macros.svh"

module control_unit
    import mips_pkg::*;
(
    input  opcode_t i_opcode,
    input  logic    i_flush,        // bubble request from hazard logic
    output logic    o_reg_dest,     // EX: 1 selects rd
    output opcode_t o_alu_op,       // EX
    output logic    o_alu_src,      // EX: 1 selects immediate
    output logic    o_mem_read,     // MEM
    output logic    o_mem_write,    // MEM
    output logic    o_branch,       // MEM
    output logic    o_reg_write,    // WB
    output logic    o_mem_to_reg,   // WB: 1 selects memory data
    output logic    o_jump
);

    always_comb begin
        o_reg_dest   = 1'b0;
        o_alu_op     = '0;
        o_alu_src    = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_branch     = 1'b0;
        o_reg_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_jump       = 1'b0;

        // unknown opcodes fall through with everything inactive
        if (!i_flush) begin
            case (i_opcode)
                `RTYPE_OPCODE: begin
                    o_alu_op    = i_opcode;
                    o_reg_dest  = 1'b1;     // write rd
                    o_reg_write = 1'b1;
                end
                `ADDI_OPCODE, `SLTI_OPCODE, `ANDI_OPCODE,
                `ORI_OPCODE, `XORI_OPCODE, `LUI_OPCODE: begin
                    o_alu_op    = i_opcode;
                    o_alu_src   = 1'b1;     // write rt from alu
                    o_reg_write = 1'b1;
                end
                `LB_OPCODE, `LH_OPCODE, `LHU_OPCODE,
                `LW_OPCODE, `LWU_OPCODE, `LBU_OPCODE: begin
                    o_alu_op     = i_opcode;
                    o_alu_src    = 1'b1;    // base + offset
                    o_mem_read   = 1'b1;
                    o_reg_write  = 1'b1;
                    o_mem_to_reg = 1'b1;
                end
                `SB_OPCODE, `SH_OPCODE, `SW_OPCODE: begin
                    o_alu_op    = i_opcode;
                    o_alu_src   = 1'b1;
                    o_mem_write = 1'b1;
                end
                `BEQ_OPCODE, `BNE_OPCODE: begin
                    o_alu_op = i_opcode;
                    o_branch = 1'b1;        // compare rs with rt
                end
                `J_OPCODE, `JAL_OPCODE: begin
                    o_alu_op = i_opcode;
                    o_jump   = 1'b1;
                end
                default: begin
                    o_alu_op = '0;
                end
            endcase
        end
    end

endmodule

//--- hw/register_file.sv
`include "mips_macros.svh"

module register_file
    import mips_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_write,          // writeback enable from WB
    input  reg_addr_t i_write_addr,
    input  word_t     i_write_data,
    input  reg_addr_t i_read_addr_a,    // rs
    input  reg_addr_t i_read_addr_b,    // rt
    output word_t     o_read_data_a,
    output word_t     o_read_data_b
);

    word_t regs [`N_REGS];

    logic write_valid;

    assign write_valid = i_write && (i_write_addr != '0);  // r0 is never written

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_valid) begin
            regs[i_write_addr] <= i_write_data;
        end
    end

    // same cycle writeback is forwarded to the readers
    assign o_read_data_a = (write_valid && i_write_addr == i_read_addr_a) ? i_write_data :
                           regs[i_read_addr_a];

    assign o_read_data_b = (write_valid && i_write_addr == i_read_addr_b) ? i_write_data :
                           regs[i_read_addr_b];

endmodule

//--- hw/imm_extend.sv
`include "mips_macros.svh"

module imm_extend
    import mips_pkg::*;
(
    input  opcode_t i_opcode,
    input  imm_t    i_imm,
    output word_t   o_imm_ext
);

    localparam int NB_EXT = `NB_DATA - `NB_IMM;

    always_comb begin
        case (i_opcode)
            `ANDI_OPCODE, `ORI_OPCODE, `XORI_OPCODE: begin
                o_imm_ext = {{NB_EXT{1'b0}}, i_imm};        // logical ops
            end
            `LUI_OPCODE: begin
                o_imm_ext = {i_imm, {NB_EXT{1'b0}}};        // upper half, low half zero
            end
            default: begin
                o_imm_ext = {{NB_EXT{i_imm[`NB_IMM-1]}}, i_imm};  // arith, mem offsets, branches
            end
        endcase
    end

endmodule

//--- hw/id_ex_latch.sv
module id_ex_latch
    import mips_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_enable,      // low holds the stage
    input  logic         i_flush,       // wins over i_enable
    input  logic         i_reg_dest,
    input  opcode_t      i_alu_op,
    input  logic         i_alu_src,
    input  logic         i_mem_read,
    input  logic         i_mem_write,
    input  logic         i_branch,
    input  logic         i_reg_write,
    input  logic         i_mem_to_reg,
    input  logic         i_jump,
    input  word_t        i_rs_data,
    input  word_t        i_rt_data,
    input  word_t        i_imm_ext,
    input  reg_addr_t    i_rt_addr,
    input  reg_addr_t    i_rd_addr,
    input  funct_t       i_funct,
    input  jump_target_t i_jump_target,
    output logic         o_reg_dest,
    output opcode_t      o_alu_op,
    output logic         o_alu_src,
    output logic         o_mem_read,
    output logic         o_mem_write,
    output logic         o_branch,
    output logic         o_reg_write,
    output logic         o_mem_to_reg,
    output logic         o_jump,
    output word_t        o_rs_data,
    output word_t        o_rt_data,
    output word_t        o_imm_ext,
    output reg_addr_t    o_rt_addr,
    output reg_addr_t    o_rd_addr,
    output funct_t       o_funct,
    output jump_target_t o_jump_target
);

    always_ff @(posedge i_clock) begin
        if (i_reset || i_flush) begin
            o_reg_dest    <= 1'b0;          // bubble
            o_alu_op      <= '0;
            o_alu_src     <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_branch      <= 1'b0;
            o_reg_write   <= 1'b0;
            o_mem_to_reg  <= 1'b0;
            o_jump        <= 1'b0;
            o_rs_data     <= '0;
            o_rt_data     <= '0;
            o_imm_ext     <= '0;
            o_rt_addr     <= '0;
            o_rd_addr     <= '0;
            o_funct       <= '0;
            o_jump_target <= '0;
        end else if (i_enable) begin
            o_reg_dest    <= i_reg_dest;
            o_alu_op      <= i_alu_op;
            o_alu_src     <= i_alu_src;
            o_mem_read    <= i_mem_read;
            o_mem_write   <= i_mem_write;
            o_branch      <= i_branch;
            o_reg_write   <= i_reg_write;
            o_mem_to_reg  <= i_mem_to_reg;
            o_jump        <= i_jump;
            o_rs_data     <= i_rs_data;
            o_rt_data     <= i_rt_data;
            o_imm_ext     <= i_imm_ext;
            o_rt_addr     <= i_rt_addr;
            o_rd_addr     <= i_rd_addr;
            o_funct       <= i_funct;
            o_jump_target <= i_jump_target;
        end
    end

endmodule

//--- hw/decode_stage.sv
`include "mips_macros.svh"

module decode_stage
    import mips_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  word_t        i_instruction,     // from IF/ID
    input  logic         i_enable,          // low stalls ID/EX
    input  logic         i_flush,
    input  logic         i_wb_write,        // writeback port from WB
    input  reg_addr_t    i_wb_addr,
    input  word_t        i_wb_data,
    output logic         o_reg_dest,
    output opcode_t      o_alu_op,
    output logic         o_alu_src,
    output logic         o_mem_read,
    output logic         o_mem_write,
    output logic         o_branch,
    output logic         o_reg_write,
    output logic         o_mem_to_reg,
    output logic         o_jump,
    output word_t        o_rs_data,
    output word_t        o_rt_data,
    output word_t        o_imm_ext,
    output reg_addr_t    o_rt_addr,
    output reg_addr_t    o_rd_addr,
    output funct_t       o_funct,
    output jump_target_t o_jump_target
);

    opcode_t      opcode;
    reg_addr_t    rs_addr;
    reg_addr_t    rt_addr;
    reg_addr_t    rd_addr;
    funct_t       funct;
    imm_t         imm;
    jump_target_t jump_target;

    logic    reg_dest;
    opcode_t alu_op;
    logic    alu_src;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    reg_write;
    logic    mem_to_reg;
    logic    jump;
    word_t   rs_data;
    word_t   rt_data;
    word_t   imm_ext;

    // standard mips field layout
    assign opcode      = i_instruction[`NB_DATA-1 -: `NB_OPCODE];
    assign rs_addr     = i_instruction[25:21];
    assign rt_addr     = i_instruction[20:16];
    assign rd_addr     = i_instruction[15:11];
    assign funct       = i_instruction[`NB_FUNCT-1:0];
    assign imm         = i_instruction[`NB_IMM-1:0];
    assign jump_target = i_instruction[`NB_DATA-`NB_OPCODE-1:0];

    control_unit u_control_unit (
        .i_opcode     (opcode),
        .i_flush      (i_flush),
        .o_reg_dest   (reg_dest),
        .o_alu_op     (alu_op),
        .o_alu_src    (alu_src),
        .o_mem_read   (mem_read),
        .o_mem_write  (mem_write),
        .o_branch     (branch),
        .o_reg_write  (reg_write),
        .o_mem_to_reg (mem_to_reg),
        .o_jump       (jump)
    );

    register_file u_register_file (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_write       (i_wb_write),
        .i_write_addr  (i_wb_addr),
        .i_write_data  (i_wb_data),
        .i_read_addr_a (rs_addr),
        .i_read_addr_b (rt_addr),
        .o_read_data_a (rs_data),
        .o_read_data_b (rt_data)
    );

    imm_extend u_imm_extend (
        .i_opcode  (opcode),
        .i_imm     (imm),
        .o_imm_ext (imm_ext)
    );

    // flush here also zeroes the data fields
    id_ex_latch u_id_ex_latch (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_flush       (i_flush),
        .i_reg_dest    (reg_dest),
        .i_alu_op      (alu_op),
        .i_alu_src     (alu_src),
        .i_mem_read    (mem_read),
        .i_mem_write   (mem_write),
        .i_branch      (branch),
        .i_reg_write   (reg_write),
        .i_mem_to_reg  (mem_to_reg),
        .i_jump        (jump),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_imm_ext     (imm_ext),
        .i_rt_addr     (rt_addr),
        .i_rd_addr     (rd_addr),
        .i_funct       (funct),
        .i_jump_target (jump_target),
        .o_reg_dest    (o_reg_dest),
        .o_alu_op      (o_alu_op),
        .o_alu_src     (o_alu_src),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_branch      (o_branch),
        .o_reg_write   (o_reg_write),
        .o_mem_to_reg  (o_mem_to_reg),
        .o_jump        (o_jump),
        .o_rs_data     (o_rs_data),
        .o_rt_data     (o_rt_data),
        .o_imm_ext     (o_imm_ext),
        .o_rt_addr     (o_rt_addr),
        .o_rd_addr     (o_rd_addr),
        .o_funct       (o_funct),
        .o_jump_target (o_jump_target)
    );

endmodule

//--- testbench/decode_checker.sv
module decode_checker
    import mips_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_valid,         // expected values present this cycle
    input  int           i_index,
    input  logic [7:0]   i_exp_ctrl,
    input  opcode_t      i_exp_alu_op,
    input  word_t        i_exp_rs_data,
    input  word_t        i_exp_rt_data,
    input  word_t        i_exp_imm_ext,
    input  reg_addr_t    i_exp_rt_addr,
    input  reg_addr_t    i_exp_rd_addr,
    input  funct_t       i_exp_funct,
    input  jump_target_t i_exp_jump_target,
    input  logic         i_reg_dest,
    input  opcode_t      i_alu_op,
    input  logic         i_alu_src,
    input  logic         i_mem_read,
    input  logic         i_mem_write,
    input  logic         i_branch,
    input  logic         i_reg_write,
    input  logic         i_mem_to_reg,
    input  logic         i_jump,
    input  word_t        i_rs_data,
    input  word_t        i_rt_data,
    input  word_t        i_imm_ext,
    input  reg_addr_t    i_rt_addr,
    input  reg_addr_t    i_rd_addr,
    input  funct_t       i_funct,
    input  jump_target_t i_jump_target,
    output int           o_pass_count,
    output int           o_fail_count
);

    bit test_ok;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h got %h", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    // sampled mid-cycle, away from the edge where outputs change
    always @(negedge i_clock) begin
        if (i_valid) begin
            test_ok = 1'b1;
            compare_value("o_reg_dest", {31'b0, i_exp_ctrl[7]}, {31'b0, i_reg_dest});
            compare_value("o_alu_src", {31'b0, i_exp_ctrl[6]}, {31'b0, i_alu_src});
            compare_value("o_mem_read", {31'b0, i_exp_ctrl[5]}, {31'b0, i_mem_read});
            compare_value("o_mem_write", {31'b0, i_exp_ctrl[4]}, {31'b0, i_mem_write});
            compare_value("o_branch", {31'b0, i_exp_ctrl[3]}, {31'b0, i_branch});
            compare_value("o_reg_write", {31'b0, i_exp_ctrl[2]}, {31'b0, i_reg_write});
            compare_value("o_mem_to_reg", {31'b0, i_exp_ctrl[1]}, {31'b0, i_mem_to_reg});
            compare_value("o_jump", {31'b0, i_exp_ctrl[0]}, {31'b0, i_jump});
            compare_value("o_alu_op", {26'b0, i_exp_alu_op}, {26'b0, i_alu_op});
            compare_value("o_rs_data", i_exp_rs_data, i_rs_data);
            compare_value("o_rt_data", i_exp_rt_data, i_rt_data);
            compare_value("o_imm_ext", i_exp_imm_ext, i_imm_ext);
            compare_value("o_rt_addr", {27'b0, i_exp_rt_addr}, {27'b0, i_rt_addr});
            compare_value("o_rd_addr", {27'b0, i_exp_rd_addr}, {27'b0, i_rd_addr});
            compare_value("o_funct", {26'b0, i_exp_funct}, {26'b0, i_funct});
            compare_value("o_jump_target", {6'b0, i_exp_jump_target},
                          {6'b0, i_jump_target});
            if (test_ok) begin
                o_pass_count = o_pass_count + 1;
                $display("test %0d passed", i_index);
            end else begin
                o_fail_count = o_fail_count + 1;
                $display("test %0d failed", i_index);
            end
        end
    end

endmodule

//--- testbench/decode_asserts.sv
module decode_asserts
    import mips_pkg::*;
(
    input logic    i_clock,
    input logic    i_reset,
    input logic    i_enable,
    input logic    i_flush,
    input logic    o_reg_dest,
    input opcode_t o_alu_op,
    input logic    o_alu_src,
    input logic    o_mem_read,
    input logic    o_mem_write,
    input logic    o_branch,
    input logic    o_reg_write,
    input logic    o_mem_to_reg,
    input logic    o_jump,
    input word_t   o_rs_data,
    input word_t   o_rt_data,
    input word_t   o_imm_ext
);

    logic [7:0] ctrl_bits;

    assign ctrl_bits = {o_reg_dest, o_alu_src, o_mem_read, o_mem_write,
                        o_branch, o_reg_write, o_mem_to_reg, o_jump};

    // a load and a store never issue together
    mem_exclusive : assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_mem_read && o_mem_write))
        else $error("mem_read and mem_write both high");

    flush_bubble : assert property (@(posedge i_clock) disable iff (i_reset)
        i_flush |=> (ctrl_bits == '0 && o_alu_op == '0))
        else $error("control outputs not cleared after flush");

    stall_hold : assert property (@(posedge i_clock) disable iff (i_reset)
        (!i_enable && !i_flush) |=> $stable({ctrl_bits, o_alu_op, o_rs_data,
                                             o_rt_data, o_imm_ext}))
        else $error("outputs changed during stall");

endmodule

//--- testbench/decode_tb.sv
module decode_tb
    import mips_pkg::*;
;

    localparam int MAX_TESTS    = 64;
    localparam int RESET_CYCLES = 16;

    logic i_clock;
    logic i_reset;
    word_t instruction;
    logic enable;
    logic flush;
    logic wb_write;
    reg_addr_t wb_addr;
    word_t wb_data;

    logic reg_dest, alu_src, mem_read, mem_write, branch;
    logic reg_write, mem_to_reg, jump;
    opcode_t alu_op;
    word_t rs_data, rt_data, imm_ext;
    reg_addr_t rt_addr, rd_addr;
    funct_t funct;
    jump_target_t jump_target;

    // test table loaded from the data file
    word_t      t_instr [MAX_TESTS];
    logic       t_en [MAX_TESTS];
    logic       t_flush [MAX_TESTS];
    logic       t_wb_write [MAX_TESTS];
    reg_addr_t  t_wb_addr [MAX_TESTS];
    word_t      t_wb_data [MAX_TESTS];
    logic [7:0] t_ctrl [MAX_TESTS];
    opcode_t    t_alu [MAX_TESTS];
    word_t      t_rs [MAX_TESTS];
    word_t      t_rt [MAX_TESTS];
    word_t      t_imm [MAX_TESTS];

    // instruction fields expected on the pass-through outputs
    reg_addr_t    t_rt_addr [MAX_TESTS];
    reg_addr_t    t_rd_addr [MAX_TESTS];
    funct_t       t_funct [MAX_TESTS];
    jump_target_t t_target [MAX_TESTS];

    logic chk_valid;
    int chk_index;
    logic [7:0] exp_ctrl;
    opcode_t exp_alu;
    word_t exp_rs, exp_rt, exp_imm;
    reg_addr_t exp_rt_addr, exp_rd_addr;
    funct_t exp_funct;
    jump_target_t exp_target;
    int pass_count, fail_count;
    int n_tests;
    int cycle_count;
    int cycle_limit;

    decode_stage dut (
        .i_clock(i_clock), .i_reset(i_reset), .i_instruction(instruction),
        .i_enable(enable), .i_flush(flush), .i_wb_write(wb_write),
        .i_wb_addr(wb_addr), .i_wb_data(wb_data),
        .o_reg_dest(reg_dest), .o_alu_op(alu_op), .o_alu_src(alu_src),
        .o_mem_read(mem_read), .o_mem_write(mem_write), .o_branch(branch),
        .o_reg_write(reg_write), .o_mem_to_reg(mem_to_reg), .o_jump(jump),
        .o_rs_data(rs_data), .o_rt_data(rt_data), .o_imm_ext(imm_ext),
        .o_rt_addr(rt_addr), .o_rd_addr(rd_addr), .o_funct(funct),
        .o_jump_target(jump_target)
    );

    decode_checker u_checker (
        .i_clock(i_clock), .i_valid(chk_valid), .i_index(chk_index),
        .i_exp_ctrl(exp_ctrl), .i_exp_alu_op(exp_alu), .i_exp_rs_data(exp_rs),
        .i_exp_rt_data(exp_rt), .i_exp_imm_ext(exp_imm),
        .i_exp_rt_addr(exp_rt_addr), .i_exp_rd_addr(exp_rd_addr),
        .i_exp_funct(exp_funct), .i_exp_jump_target(exp_target),
        .i_reg_dest(reg_dest), .i_alu_op(alu_op), .i_alu_src(alu_src),
        .i_mem_read(mem_read), .i_mem_write(mem_write), .i_branch(branch),
        .i_reg_write(reg_write), .i_mem_to_reg(mem_to_reg), .i_jump(jump),
        .i_rs_data(rs_data), .i_rt_data(rt_data), .i_imm_ext(imm_ext),
        .i_rt_addr(rt_addr), .i_rd_addr(rd_addr), .i_funct(funct),
        .i_jump_target(jump_target),
        .o_pass_count(pass_count), .o_fail_count(fail_count)
    );

    bind decode_stage decode_asserts u_decode_asserts (
        .i_clock(i_clock), .i_reset(i_reset), .i_enable(i_enable),
        .i_flush(i_flush), .o_reg_dest(o_reg_dest), .o_alu_op(o_alu_op),
        .o_alu_src(o_alu_src), .o_mem_read(o_mem_read), .o_mem_write(o_mem_write),
        .o_branch(o_branch), .o_reg_write(o_reg_write), .o_mem_to_reg(o_mem_to_reg),
        .o_jump(o_jump), .o_rs_data(o_rs_data), .o_rt_data(o_rt_data),
        .o_imm_ext(o_imm_ext)
    );

    always #4 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic load_tests();
        int fd;
        int n;
        string line;
        logic [31:0] f [11];
        fd = $fopen("testbench/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (line.len() > 0 && line[0] != "#" && n == 11) begin   // skip comments
                    t_instr[n_tests]    = f[0];
                    t_en[n_tests]       = f[1][0];
                    t_flush[n_tests]    = f[2][0];
                    t_wb_write[n_tests] = f[3][0];
                    t_wb_addr[n_tests]  = f[4][4:0];
                    t_wb_data[n_tests]  = f[5];
                    t_ctrl[n_tests]     = f[6][7:0];
                    t_alu[n_tests]      = f[7][5:0];
                    t_rs[n_tests]       = f[8];
                    t_rt[n_tests]       = f[9];
                    t_imm[n_tests]      = f[10];
                    n_tests = n_tests + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    // pass-through fields are cleared by flush and held while the stage is stalled
    task automatic derive_field_expectations();
        reg_addr_t    held_rt;
        reg_addr_t    held_rd;
        funct_t       held_funct;
        jump_target_t held_target;
        held_rt = '0;                           // stage is empty after reset
        held_rd = '0;
        held_funct = '0;
        held_target = '0;
        for (int k = 0; k < n_tests; k++) begin
            if (t_flush[k]) begin
                held_rt = '0;
                held_rd = '0;
                held_funct = '0;
                held_target = '0;
            end else if (t_en[k]) begin
                held_rt = t_instr[k][20:16];    // mips instruction format
                held_rd = t_instr[k][15:11];
                held_funct = t_instr[k][5:0];
                held_target = t_instr[k][25:0];
            end
            t_rt_addr[k] = held_rt;
            t_rd_addr[k] = held_rd;
            t_funct[k] = held_funct;
            t_target[k] = held_target;
        end
    endtask

    initial begin
        i_clock = 1'b0;
        i_reset = 1'b1;
        instruction = '0;
        enable = 1'b0;
        flush = 1'b0;
        wb_write = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        chk_valid = 1'b0;
        chk_index = 0;
        exp_ctrl = '0;
        exp_alu = '0;
        exp_rs = '0;
        exp_rt = '0;
        exp_imm = '0;
        exp_rt_addr = '0;
        exp_rd_addr = '0;
        exp_funct = '0;
        exp_target = '0;
        n_tests = 0;
        cycle_count = 0;
        cycle_limit = RESET_CYCLES + 20;
        load_tests();
        derive_field_expectations();
        cycle_limit = n_tests + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge i_clock);
        #1 i_reset = 1'b0;

        for (int k = 0; k <= n_tests; k++) begin
            @(posedge i_clock);
            #1;
            if (k < n_tests) begin
                instruction = t_instr[k];
                enable = t_en[k];
                flush = t_flush[k];
                wb_write = t_wb_write[k];
                wb_addr = t_wb_addr[k];
                wb_data = t_wb_data[k];
            end else begin
                enable = 1'b0;                  // park the stage
                flush = 1'b0;
                wb_write = 1'b0;
            end
            // outputs lag the stimulus by one cycle
            if (k > 0) begin
                chk_valid = 1'b1;
                chk_index = k - 1;
                exp_ctrl = t_ctrl[k-1];
                exp_alu = t_alu[k-1];
                exp_rs = t_rs[k-1];
                exp_rt = t_rt[k-1];
                exp_imm = t_imm[k-1];
                exp_rt_addr = t_rt_addr[k-1];
                exp_rd_addr = t_rd_addr[k-1];
                exp_funct = t_funct[k-1];
                exp_target = t_target[k-1];
            end
        end
        @(posedge i_clock);
        chk_valid = 1'b0;

        $display("%0d tests, %0d passed, %0d failed", n_tests, pass_count, fail_count);
        if (n_tests > 0 && fail_count == 0 && pass_count == n_tests) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/mips_pkg.sv
hw/control_unit.sv
hw/register_file.sv
hw/imm_extend.sv
hw/id_ex_latch.sv
hw/decode_stage.sv
testbench/decode_checker.sv
testbench/decode_asserts.sv
testbench/decode_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module decode_tb \
    -o decode_sim

./obj_dir/decode_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

//--- testbench/decode_tests.txt
# instr    en fl wbw wba wbdata   | ctrl alu rs_data  rt_data  imm_ext
# ctrl bits: reg_dest alu_src mem_read mem_write branch reg_write mem_to_reg jump
20010005 0 0 1 01 11111111 00 00 00000000 00000000 00000000
00221820 1 0 1 02 22222222 84 00 11111111 22222222 00001820
2064fff0 1 0 0 00 00000000 44 08 00000000 00000000 fffffff0
20008000 1 0 1 00 deadbeef 44 08 00000000 00000000 ffff8000
28220001 1 0 0 00 00000000 44 0a 11111111 22222222 00000001
30228000 1 0 0 00 00000000 44 0c 11111111 22222222 00008000
3422ffff 1 0 0 00 00000000 44 0d 11111111 22222222 0000ffff
38221234 1 0 0 00 00000000 44 0e 11111111 22222222 00001234
3c02abcd 1 0 0 00 00000000 44 0f 00000000 22222222 abcd0000
8022fffc 1 0 0 00 00000000 66 20 11111111 22222222 fffffffc
84220004 1 0 0 00 00000000 66 21 11111111 22222222 00000004
88220004 1 0 0 00 00000000 66 22 11111111 22222222 00000004
8c220008 1 0 0 00 00000000 66 23 11111111 22222222 00000008
90228000 1 0 0 00 00000000 66 24 11111111 22222222 ffff8000
94220001 1 0 0 00 00000000 66 25 11111111 22222222 00000001
a0220010 1 0 0 00 00000000 50 28 11111111 22222222 00000010
a4220010 1 0 0 00 00000000 50 29 11111111 22222222 00000010
ac22fff8 1 0 0 00 00000000 50 2b 11111111 22222222 fffffff8
1022fffe 1 0 0 00 00000000 08 04 11111111 22222222 fffffffe
14220003 1 0 0 00 00000000 08 05 11111111 22222222 00000003
08001234 1 0 0 00 00000000 01 02 00000000 00000000 00001234
0c22ffff 1 0 0 00 00000000 01 03 11111111 22222222 ffffffff
fc221234 1 0 0 00 00000000 00 00 11111111 22222222 00001234
20a60007 0 0 1 05 55555555 00 00 11111111 22222222 00001234
20a60007 1 0 0 00 00000000 44 08 55555555 00000000 00000007
8c220008 0 1 0 00 00000000 00 00 00000000 00000000 00000000
ac22fff8 1 1 0 00 00000000 00 00 00000000 00000000 00000000
